// ==== common/cache_pkg.sv ====
package cache_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;

    // Cache geometry, the address is a word address
    localparam int LINE_WORDS = 4;
    localparam int OFFSET_W   = $clog2(LINE_WORDS);
    localparam int INDEX_W    = 6;
    localparam int LINES      = 1 << INDEX_W;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

    // Request from a CPU port
    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   byteenable;
        logic [DATA_W-1:0] writedata;
    } cpu_req_t;

    // Request toward memory
    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   byteenable;
        logic [DATA_W-1:0] writedata;
    } mem_req_t;

    // One cache's request toward the arbiter
    typedef struct packed {
        mem_req_t req;
        logic     fill_lock;
    } cache_mem_req_t;

    // Line fill sequencer
    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_ISSUE,
        FILL_DRAIN
    } fill_state_t;

    // Memory port owner
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_PORT0,
        ARB_PORT1
    } arb_state_t;

endpackage

// ==== l1cache/line_fill_queue.sv ====
`timescale 1ns/1ps

module line_fill_queue (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  logic [cache_pkg::ADDR_W-1:0]   line_addr,
    input  logic                           mem_waitrequest,
    input  logic [cache_pkg::DATA_W-1:0]   mem_readdata,
    output logic                           read,
    output logic [cache_pkg::ADDR_W-1:0]   addr,
    output logic                           busy,
    output logic                           word_we,
    output logic [cache_pkg::OFFSET_W-1:0] word_offset,
    output logic [cache_pkg::DATA_W-1:0]   word_data,
    output logic                           done
);
    import cache_pkg::*;

    fill_state_t                state;
    logic [ADDR_W-OFFSET_W-1:0] line_base;
    logic [OFFSET_W-1:0]        issue_cnt;
    logic [OFFSET_W-1:0]        ret_cnt;
    logic                       accepted_q;

    assign read = (state == FILL_ISSUE);
    assign addr = {line_base, issue_cnt};
    assign busy = (state != FILL_IDLE);

    // Memory answers one cycle after acceptance
    assign word_we     = accepted_q;
    assign word_offset = ret_cnt;
    assign word_data   = mem_readdata;
    assign done        = accepted_q && (ret_cnt == OFFSET_W'(LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (state == FILL_IDLE && start) begin
            line_base <= line_addr[ADDR_W-1:OFFSET_W];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= FILL_IDLE;
            issue_cnt  <= '0;
            ret_cnt    <= '0;
            accepted_q <= 1'b0;
        end else begin
            accepted_q <= read && !mem_waitrequest;
            if (accepted_q) begin
                ret_cnt <= ret_cnt + 1'b1;
            end
            case (state)
                FILL_IDLE: begin
                    if (start) begin
                        state     <= FILL_ISSUE;
                        issue_cnt <= '0;
                        ret_cnt   <= '0;
                    end
                end
                FILL_ISSUE: begin
                    if (!mem_waitrequest) begin
                        issue_cnt <= issue_cnt + 1'b1;
                        if (issue_cnt == OFFSET_W'(LINE_WORDS - 1)) begin
                            state <= FILL_DRAIN;
                        end
                    end
                end
                FILL_DRAIN: begin
                    // Up to one read still in flight here
                    if (done) begin
                        state <= FILL_IDLE;
                    end
                end
                default: state <= FILL_IDLE;
            endcase
        end
    end

endmodule

// ==== l1cache/l1cache.sv ====
`timescale 1ns/1ps

module l1cache (
    input  logic                             clk,
    input  logic                             reset,
    input  cache_pkg::cpu_req_t              cpu_req,
    output logic [cache_pkg::DATA_W-1:0]     readdata,
    output logic                             waitrequest,
    output cache_pkg::cache_mem_req_t        mem_req,
    input  logic [cache_pkg::DATA_W-1:0]     mem_readdata,
    input  logic                             mem_waitrequest
);
    import cache_pkg::*;

    // Byte lane mask, bit 0 of byteenable is the low byte
    function automatic logic [DATA_W-1:0] lane_mask(input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] mask;
        for (int i = 0; i < BE_W; i++) begin
            mask[8*i +: 8] = {8{be[i]}};
        end
        return mask;
    endfunction

    logic [LINES-1:0]  valid_bits;
    logic [TAG_W-1:0]  tag_mem [LINES];
    logic [DATA_W-1:0] data_mem [LINES*LINE_WORDS];

    logic [TAG_W-1:0]            cpu_tag;
    logic [INDEX_W-1:0]          cpu_index;
    logic [OFFSET_W-1:0]         cpu_offset;
    logic [INDEX_W+OFFSET_W-1:0] word_sel;
    logic [DATA_W-1:0]           be_mask;
    logic                        hit;
    logic                        write_hit_accept;

    logic                  fill_start;
    logic                  fill_read;
    logic [ADDR_W-1:0]     fill_addr;
    logic                  fill_busy;
    logic                  fill_word_we;
    logic [OFFSET_W-1:0]   fill_word_offset;
    logic [DATA_W-1:0]     fill_word_data;
    logic                  fill_done;

    assign cpu_tag    = cpu_req.addr[ADDR_W-1 -: TAG_W];
    assign cpu_index  = cpu_req.addr[OFFSET_W +: INDEX_W];
    assign cpu_offset = cpu_req.addr[OFFSET_W-1:0];
    assign word_sel   = {cpu_index, cpu_offset};
    assign be_mask    = lane_mask(cpu_req.byteenable);

    assign hit = valid_bits[cpu_index] && (tag_mem[cpu_index] == cpu_tag);

    // Writes complete when memory takes them, reads when they hit
    assign waitrequest = (cpu_req.read && !hit) || (cpu_req.write && mem_waitrequest);

    assign write_hit_accept = cpu_req.write && !mem_waitrequest && hit;

    // CPU holds a missing read, so its index stays valid through the fill
    assign fill_start = cpu_req.read && !hit && !fill_busy;

    line_fill_queue u_fill (
        .clk             (clk),
        .reset           (reset),
        .start           (fill_start),
        .line_addr       (cpu_req.addr),
        .mem_waitrequest (mem_waitrequest),
        .mem_readdata    (mem_readdata),
        .read            (fill_read),
        .addr            (fill_addr),
        .busy            (fill_busy),
        .word_we         (fill_word_we),
        .word_offset     (fill_word_offset),
        .word_data       (fill_word_data),
        .done            (fill_done)
    );

    always_comb begin
        mem_req           = '0;
        mem_req.fill_lock = fill_busy;
        if (cpu_req.write) begin
            mem_req.req.write      = 1'b1;
            mem_req.req.addr       = cpu_req.addr;
            mem_req.req.byteenable = cpu_req.byteenable;
            mem_req.req.writedata  = cpu_req.writedata;
        end else begin
            // Fill reads always fetch the full word
            mem_req.req.read       = fill_read;
            mem_req.req.addr       = fill_addr;
            mem_req.req.byteenable = '1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (fill_done) begin
            valid_bits[cpu_index] <= 1'b1;
        end else if (fill_start) begin
            // Old line is being replaced
            valid_bits[cpu_index] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_mem[cpu_index] <= cpu_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_word_we) begin
            data_mem[{cpu_index, fill_word_offset}] <= fill_word_data;
        end else if (write_hit_accept) begin
            data_mem[word_sel] <= (data_mem[word_sel] & ~be_mask)
                                | (cpu_req.writedata & be_mask);
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req.read && hit) begin
            readdata <= data_mem[word_sel] & be_mask;
        end
    end

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                         clk,
    input  logic                         reset,
    input  cache_pkg::cache_mem_req_t    req0,
    input  cache_pkg::cache_mem_req_t    req1,
    output logic                         waitrequest0,
    output logic                         waitrequest1,
    output logic [cache_pkg::DATA_W-1:0] readdata0,
    output logic [cache_pkg::DATA_W-1:0] readdata1,
    output cache_pkg::mem_req_t          mem_req,
    input  logic [cache_pkg::DATA_W-1:0] mem_readdata,
    input  logic                         mem_waitrequest
);
    import cache_pkg::*;

    arb_state_t state;
    arb_state_t state_next;
    logic       active0;
    logic       active1;
    logic       strobe0;
    logic       strobe1;
    logic       grant0;
    logic       grant1;
    logic       last_port1;

    assign strobe0 = req0.req.read | req0.req.write;
    assign strobe1 = req1.req.read | req1.req.write;
    assign active0 = strobe0 | req0.fill_lock;
    assign active1 = strobe1 | req1.fill_lock;

    // Grant is decided in the same cycle as the request
    always_comb begin
        grant0 = 1'b0;
        grant1 = 1'b0;
        case (state)
            ARB_PORT0: grant0 = 1'b1;
            ARB_PORT1: grant1 = 1'b1;
            default: begin
                if (active0 && active1) begin
                    grant0 = last_port1;
                    grant1 = !last_port1;
                end else begin
                    grant0 = active0;
                    grant1 = active1;
                end
            end
        endcase
    end

    // Hold through a fill or an unaccepted strobe
    always_comb begin
        state_next = ARB_IDLE;
        if (grant0 && (req0.fill_lock || (strobe0 && mem_waitrequest))) begin
            state_next = ARB_PORT0;
        end else if (grant1 && (req1.fill_lock || (strobe1 && mem_waitrequest))) begin
            state_next = ARB_PORT1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ARB_IDLE;
            last_port1 <= 1'b0;
        end else begin
            state <= state_next;
            if (state == ARB_IDLE && (grant0 || grant1)) begin
                last_port1 <= grant1;
            end
        end
    end

    always_comb begin
        mem_req = '0;
        if (grant0) begin
            mem_req = req0.req;
        end else if (grant1) begin
            mem_req = req1.req;
        end
    end

    assign waitrequest0 = grant0 ? mem_waitrequest : 1'b1;
    assign waitrequest1 = grant1 ? mem_waitrequest : 1'b1;

    // Only the owner of the read is looking at this
    assign readdata0 = mem_readdata;
    assign readdata1 = mem_readdata;

endmodule

// ==== design/dual_cache_top.sv ====
`timescale 1ns/1ps

module dual_cache_top (
    input  logic                         clk,
    input  logic                         reset,
    input  cache_pkg::cpu_req_t          cpu_req0,
    input  cache_pkg::cpu_req_t          cpu_req1,
    output logic [cache_pkg::DATA_W-1:0] readdata0,
    output logic [cache_pkg::DATA_W-1:0] readdata1,
    output logic                         waitrequest0,
    output logic                         waitrequest1,
    output cache_pkg::mem_req_t          mem_req,
    input  logic [cache_pkg::DATA_W-1:0] mem_readdata,
    input  logic                         mem_waitrequest
);
    import cache_pkg::*;

    cache_mem_req_t    cache_req0;
    cache_mem_req_t    cache_req1;
    logic              arb_wait0;
    logic              arb_wait1;
    logic [DATA_W-1:0] arb_rdata0;
    logic [DATA_W-1:0] arb_rdata1;

    l1cache u_cache0 (
        .clk             (clk),
        .reset           (reset),
        .cpu_req         (cpu_req0),
        .readdata        (readdata0),
        .waitrequest     (waitrequest0),
        .mem_req         (cache_req0),
        .mem_readdata    (arb_rdata0),
        .mem_waitrequest (arb_wait0)
    );

    l1cache u_cache1 (
        .clk             (clk),
        .reset           (reset),
        .cpu_req         (cpu_req1),
        .readdata        (readdata1),
        .waitrequest     (waitrequest1),
        .mem_req         (cache_req1),
        .mem_readdata    (arb_rdata1),
        .mem_waitrequest (arb_wait1)
    );

    mem_arbiter u_arb (
        .clk             (clk),
        .reset           (reset),
        .req0            (cache_req0),
        .req1            (cache_req1),
        .waitrequest0    (arb_wait0),
        .waitrequest1    (arb_wait1),
        .readdata0       (arb_rdata0),
        .readdata1       (arb_rdata1),
        .mem_req         (mem_req),
        .mem_readdata    (mem_readdata),
        .mem_waitrequest (mem_waitrequest)
    );

endmodule

// ==== test/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== test/dual_cache_properties.sv ====
`timescale 1ns/1ps

module dual_cache_properties (
    input logic                clk,
    input logic                reset,
    input cache_pkg::mem_req_t mem_req,
    input logic                mem_waitrequest
);

    logic strobe;

    assign strobe = mem_req.read || mem_req.write;

    one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.read && mem_req.write))
        else $error("memory read and write asserted together");

    // Requester holds everything while memory stalls
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        (strobe && mem_waitrequest) |=> $stable(mem_req))
        else $error("memory request changed under waitrequest");

    idle_after_reset: assert property (@(posedge clk)
        reset |=> !strobe)
        else $error("memory strobe high right after reset");

endmodule

bind dual_cache_top dual_cache_properties u_props (
    .clk             (clk),
    .reset           (reset),
    .mem_req         (mem_req),
    .mem_waitrequest (mem_waitrequest)
);

// ==== test/dual_cache_tb.sv ====
`timescale 1ns/1ps

module dual_cache_tb;
    import cache_pkg::*;

    localparam int MAX_OPS = 64;

    logic                clk;
    logic                reset;
    cpu_req_t            cpu_req0;
    cpu_req_t            cpu_req1;
    logic [DATA_W-1:0]   readdata0;
    logic [DATA_W-1:0]   readdata1;
    logic                waitrequest0;
    logic                waitrequest1;
    mem_req_t            mem_req;
    logic [DATA_W-1:0]   mem_readdata;
    logic                mem_waitrequest;

    // Trace columns per port
    logic [3:0]  tr_op [2][MAX_OPS];
    logic [31:0] tr_addr [2][MAX_OPS];
    logic [3:0]  tr_be [2][MAX_OPS];
    logic [31:0] tr_wdata [2][MAX_OPS];
    logic [31:0] tr_expect [2][MAX_OPS];
    logic [31:0] tr_reads [2][MAX_OPS];
    int          op_count [2];
    int          op_idx [2];
    int          reads_seen [2];
    logic        check_pending [2];
    logic [31:0] check_expect [2];
    logic        advance [2];

    logic [31:0] memory [1024];
    logic        rd_pending;
    logic [31:0] rd_data;
    int          fill_pos;
    logic [29:0] fill_line;
    integer      seed;
    int          error_count;
    logic        loaded;

    clock_gen u_clk (
        .clk   (clk),
        .reset (reset)
    );

    dual_cache_top uut (
        .clk             (clk),
        .reset           (reset),
        .cpu_req0        (cpu_req0),
        .cpu_req1        (cpu_req1),
        .readdata0       (readdata0),
        .readdata1       (readdata1),
        .waitrequest0    (waitrequest0),
        .waitrequest1    (waitrequest1),
        .mem_req         (mem_req),
        .mem_readdata    (mem_readdata),
        .mem_waitrequest (mem_waitrequest)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [7];
        fd = $fopen("test/dual_cache_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] != 8'h23) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                if (n == 7) begin
                    tr_op[f[0][0]][op_count[f[0][0]]]     = f[1][3:0];
                    tr_addr[f[0][0]][op_count[f[0][0]]]   = f[2];
                    tr_be[f[0][0]][op_count[f[0][0]]]     = f[3][3:0];
                    tr_wdata[f[0][0]][op_count[f[0][0]]]  = f[4];
                    tr_expect[f[0][0]][op_count[f[0][0]]] = f[5];
                    tr_reads[f[0][0]][op_count[f[0][0]]]  = f[6];
                    op_count[f[0][0]]++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic present(input int p);
        cpu_req_t req;
        req = '0;
        if (op_idx[p] < op_count[p]) begin
            req.read       = (tr_op[p][op_idx[p]] == 4'd0);
            req.write      = (tr_op[p][op_idx[p]] == 4'd1);
            req.addr       = tr_addr[p][op_idx[p]];
            req.byteenable = tr_be[p][op_idx[p]];
            req.writedata  = tr_wdata[p][op_idx[p]];
        end
        reads_seen[p] = 0;
        if (p == 0) begin
            cpu_req0 = req;
        end else begin
            cpu_req1 = req;
        end
    endtask

    task automatic memory_cycle();
        int          p;
        logic [31:0] mask;
        if ((mem_req.read || mem_req.write) && !mem_waitrequest) begin
            if (mem_req.addr[31:10] != '0) begin
                abort_run("Memory access outside the modelled range");
            end
            p = mem_req.addr[9];
            if (op_idx[p] >= op_count[p]) begin
                abort_run("Memory access from a port with no request");
            end
            if (mem_req.read) begin
                if (tr_op[p][op_idx[p]] != 4'd0) begin
                    abort_run("Memory read while the port was writing");
                end
                check_value("fill order", 32'(fill_pos), 32'(mem_req.addr[1:0]));
                if (fill_pos != 0) begin
                    check_value("fill line", 32'(fill_line), 32'(mem_req.addr[31:2]));
                end
                check_value("fill address", tr_addr[p][op_idx[p]] >> 2, mem_req.addr >> 2);
                fill_line = mem_req.addr[31:2];
                fill_pos = (fill_pos + 1) % 4;
                reads_seen[p]++;
                rd_pending = 1'b1;
                rd_data = memory[mem_req.addr[9:0]];
            end else begin
                if (fill_pos != 0) begin
                    abort_run("Memory write interleaved with a line fill");
                end
                check_value("write address", tr_addr[p][op_idx[p]], mem_req.addr);
                check_value("write byteenable", 32'(tr_be[p][op_idx[p]]),
                            32'(mem_req.byteenable));
                for (int i = 0; i < 4; i++) begin
                    mask[8*i +: 8] = {8{mem_req.byteenable[i]}};
                end
                memory[mem_req.addr[9:0]] = (memory[mem_req.addr[9:0]] & ~mask)
                                          | (mem_req.writedata & mask);
            end
        end
    endtask

    task automatic port_cycle(input int p, input logic wait_n, input logic [31:0] rdata);
        advance[p] = 1'b0;
        if (check_pending[p]) begin
            check_value($sformatf("read data port %0d op %0d", p, op_idx[p] - 1),
                        check_expect[p], rdata);
            check_pending[p] = 1'b0;
        end
        if (op_idx[p] < op_count[p] && !wait_n) begin
            if (tr_op[p][op_idx[p]] == 4'd0) begin
                check_pending[p] = 1'b1;
                check_expect[p]  = tr_expect[p][op_idx[p]];
                check_value($sformatf("memory reads port %0d op %0d", p, op_idx[p]),
                            tr_reads[p][op_idx[p]], 32'(reads_seen[p]));
            end
            op_idx[p]++;
            advance[p] = 1'b1;
        end
    endtask

    initial begin
        seed            = 32'h8156;
        error_count     = 0;
        loaded          = 1'b0;
        cpu_req0        = '0;
        cpu_req1        = '0;
        mem_readdata    = '0;
        mem_waitrequest = 1'b0;
        rd_pending      = 1'b0;
        rd_data         = '0;
        fill_pos        = 0;
        fill_line       = '0;
        for (int i = 0; i < 2; i++) begin
            op_count[i]      = 0;
            op_idx[i]        = 0;
            reads_seen[i]    = 0;
            check_pending[i] = 1'b0;
            check_expect[i]  = '0;
            advance[i]       = 1'b0;
        end
        for (int a = 0; a < 1024; a++) begin
            memory[a] = 32'hC0DE0000 + a;
        end
        load_trace();
        loaded = 1'b1;

        wait (!reset);
        @(posedge clk);
        #1;
        present(0);
        present(1);
        forever begin
            #8;
            memory_cycle();
            port_cycle(0, waitrequest0, readdata0);
            port_cycle(1, waitrequest1, readdata1);
            @(posedge clk);
            #1;
            mem_readdata    = rd_pending ? rd_data : 32'h0BAD0BAD;
            rd_pending      = 1'b0;
            mem_waitrequest = (($random(seed) & 3) == 0);
            // Next trace line only after the current one completed
            if (advance[0]) begin
                present(0);
            end
            if (advance[1]) begin
                present(1);
            end
            if (op_idx[0] >= op_count[0] && op_idx[1] >= op_count[1]
                    && !check_pending[0] && !check_pending[1]) begin
                break;
            end
        end

        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the trace length
    initial begin
        wait (loaded);
        repeat (200 * (op_count[0] + op_count[1])) @(posedge clk);
        $display("The run hung before the trace finished");
        $display("CHECKS FAILED");
        $fatal(1);
    end

endmodule

// ==== test/dual_cache_trace.txt ====
# port op(0 read, 1 write) addr(word) byteenable writedata expected_read mem_reads
# all fields hex, port 0 uses words 000-1ff and port 1 uses words 200-3ff
0 0 010 f 00000000 c0de0010 4
1 0 210 f 00000000 c0de0210 4
0 0 011 f 00000000 c0de0011 0
1 0 212 f 00000000 c0de0212 0
0 0 013 3 00000000 00000013 0
1 0 2f0 3 00000000 000002f0 4
0 0 012 c 00000000 c0de0000 0
1 1 2f1 f deadbeef 00000000 0
0 1 011 1 000000ee 00000000 0
1 0 2f1 f 00000000 deadbeef 0
0 0 011 f 00000000 c0de00ee 0
1 1 300 9 aabbccdd 00000000 0
0 1 020 6 12345678 00000000 0
1 0 300 f 00000000 aade03dd 4
0 0 020 f 00000000 c0345620 4
1 0 3f0 f 00000000 c0de03f0 4
0 0 110 f 00000000 c0de0110 4
1 0 2f1 f 00000000 deadbeef 4
0 0 010 f 00000000 c0de0010 4
1 0 212 1 00000000 00000012 0
0 0 013 5 00000000 00de0013 0
0 0 1f3 8 00000000 c0000000 4

// ==== dual_cache_top.f ====
common/cache_pkg.sv
l1cache/line_fill_queue.sv
l1cache/l1cache.sv
design/mem_arbiter.sv
design/dual_cache_top.sv
test/clock_gen.sv
test/dual_cache_properties.sv
test/dual_cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1

( verilator --binary --timing --assert --top-module dual_cache_tb \
      -f dual_cache_top.f -o dual_cache_sim \
  && ./obj_dir/dual_cache_sim ) > sim.log 2>&1 \
  || echo "simulation returned an error" >> sim.log

cat sim.log
! grep -q "CHECKS FAILED" sim.log && grep -q "ALL CHECKS PASSED" sim.log \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }
